//--- src/cpu_pkg.sv
package cpu_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 4;
    localparam int mem_words  = 512;
    localparam int mem_addr_w = $clog2(mem_words);

    // instruction fields
    localparam int opcode_w = 5;
    localparam int ra_lsb   = 23;
    localparam int rb_lsb   = 19;
    localparam int rc_lsb   = 15;
    localparam int imm_w    = 19;   // sign-extended c field
    localparam int cond_lsb = 19;   // 2-bit branch condition

    localparam logic [opcode_w-1:0] op_ld     = 5'd0;
    localparam logic [opcode_w-1:0] op_ldi    = 5'd1;
    localparam logic [opcode_w-1:0] op_st     = 5'd2;
    localparam logic [opcode_w-1:0] op_add    = 5'd3;
    localparam logic [opcode_w-1:0] op_sub    = 5'd4;
    localparam logic [opcode_w-1:0] op_shr    = 5'd5;
    localparam logic [opcode_w-1:0] op_shra   = 5'd6;
    localparam logic [opcode_w-1:0] op_shl    = 5'd7;
    localparam logic [opcode_w-1:0] op_ror    = 5'd8;
    localparam logic [opcode_w-1:0] op_rol    = 5'd9;
    localparam logic [opcode_w-1:0] op_and    = 5'd10;
    localparam logic [opcode_w-1:0] op_or     = 5'd11;
    localparam logic [opcode_w-1:0] op_addi   = 5'd12;
    localparam logic [opcode_w-1:0] op_andi   = 5'd13;
    localparam logic [opcode_w-1:0] op_ori    = 5'd14;
    localparam logic [opcode_w-1:0] op_neg    = 5'd17;
    localparam logic [opcode_w-1:0] op_not    = 5'd18;
    localparam logic [opcode_w-1:0] op_branch = 5'd19;
    localparam logic [opcode_w-1:0] op_out    = 5'd22;
    localparam logic [opcode_w-1:0] op_nop    = 5'd26;
    localparam logic [opcode_w-1:0] op_halt   = 5'd27;

    typedef enum logic [5:0] {
        reset_state, fetch0, fetch1, fetch2,
        ld3, ld4, ld5, ld6, ld7,
        ldi3, ldi4, ldi5,
        st3, st4, st5, st6, st7,
        reg3, reg4, reg5,           // register alu and shift/rotate
        imm3, imm4, imm5,
        un3, un4,                   // neg, not
        br3, br4, br5, br6, br6_nt,
        out3, nop3, halted_state
    } state_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_neg, alu_not,
        alu_shr, alu_shra, alu_shl, alu_ror, alu_rol
    } alu_op_t;

    typedef struct packed {
        logic    pc_en;
        logic    ir_en;
        logic    y_en;
        logic    z_en;
        logic    mar_en;
        logic    mdr_en;
        logic    con_en;
        logic    outport_en;
        logic    pc_out;
        logic    mdr_out;
        logic    zlo_out;
        logic    r_out;
        logic    ba_out;
        logic    c_out;
        logic    gra;
        logic    grb;
        logic    grc;
        logic    r_in;
        logic    read;
        logic    write;
        logic    pc_increment;
        logic    y_clr;
        alu_op_t alu_op;
    } ctrl_t;

endpackage

//--- src/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_t     op,
    output logic [31:0] result
);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_neg: result = -b;    // unary ops use the bus operand
            alu_not: result = ~b;
            default: result = '0;    // shifts come from the rotator
        endcase
    end

endmodule

//--- src/rotator.sv
`timescale 1ns/1ps

module rotator import cpu_pkg::*; (
    input  logic [31:0] value,
    input  logic [31:0] amount,
    input  alu_op_t     op,
    output logic [31:0] result
);

    logic [4:0] amt;
    logic [63:0] dbl;
    logic [63:0] dbl_l;
    logic [63:0] dbl_r;

    assign amt = amount[4:0];
    assign dbl = {value, value};
    assign dbl_l = dbl << amt;   // upper half is rol
    assign dbl_r = dbl >> amt;   // lower half is ror

    always_comb begin
        case (op)
            alu_shr:  result = value >> amt;
            alu_shra: result = $signed(value) >>> amt;
            alu_shl:  result = value << amt;
            alu_ror:  result = dbl_r[31:0];
            alu_rol:  result = dbl_l[63:32];
            default:  result = '0;
        endcase
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] ir,
    input  logic        gra,
    input  logic        grb,
    input  logic        grc,
    input  logic        r_in,
    input  logic        ba_out,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    logic [data_w-1:0] regs [2**reg_addr_w];
    logic [reg_addr_w-1:0] sel;

    // field select from the instruction
    always_comb begin
        if (gra) begin
            sel = ir[ra_lsb +: reg_addr_w];
        end else if (grb) begin
            sel = ir[rb_lsb +: reg_addr_w];
        end else if (grc) begin
            sel = ir[rc_lsb +: reg_addr_w];
        end else begin
            sel = '0;
        end
    end

    assign rdata = (ba_out && sel == '0) ? '0 : regs[sel];  // base address rule

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (r_in) begin
            regs[sel] <= wdata;
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0({gra, grb, grc}));

endmodule

//--- src/memory.sv
`timescale 1ns/1ps

module memory import cpu_pkg::*; (
    input  logic                  clk,
    input  logic [31:0]           addr,
    input  logic [31:0]           wdata,
    input  logic                  read,
    input  logic                  write,
    output logic [31:0]           rdata,
    input  logic                  load_en,
    input  logic [mem_addr_w-1:0] load_addr,
    input  logic [31:0]           load_data
);

    logic [data_w-1:0] ram [mem_words];

    always_ff @(posedge clk) begin
        if (load_en) begin
            ram[load_addr] <= load_data;   // program load wins
        end else if (write) begin
            ram[addr[mem_addr_w-1:0]] <= wdata;
        end
        if (read) begin
            rdata <= ram[addr[mem_addr_w-1:0]];
        end
    end

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  ctrl_t       ctrl,
    input  logic [31:0] mem_rdata,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [31:0] ir,
    output logic        con_ff,
    output logic [31:0] out_data,
    output logic        out_valid
);

    logic [31:0] bus;
    logic [31:0] pc, y, z, mar, mdr, ir_q;
    logic [31:0] rf_rdata, alu_result, rot_result, z_d, c_ext;
    logic [1:0] cond;
    logic cond_met;
    logic is_shift;

    assign c_ext = {{(data_w-imm_w){ir_q[imm_w-1]}}, ir_q[imm_w-1:0]};
    assign cond = ir_q[cond_lsb +: 2];
    assign mem_addr = mar;
    assign mem_wdata = mdr;
    assign ir = ctrl.ir_en ? bus : ir_q;   // decode sees the word being fetched

    reg_file reg_file_inst (
        .clk    (clk),
        .reset  (reset),
        .ir     (ir_q),
        .gra    (ctrl.gra),
        .grb    (ctrl.grb),
        .grc    (ctrl.grc),
        .r_in   (ctrl.r_in),
        .ba_out (ctrl.ba_out),
        .wdata  (bus),
        .rdata  (rf_rdata)
    );

    alu alu_inst (.a(y), .b(bus), .op(ctrl.alu_op), .result(alu_result));

    rotator rotator_inst (.value(y), .amount(bus), .op(ctrl.alu_op), .result(rot_result));

    // one active source at a time
    always_comb begin
        if (ctrl.pc_out) begin
            bus = pc;
        end else if (ctrl.mdr_out) begin
            bus = ctrl.read ? mem_rdata : mdr;   // ram output bypasses mdr while reading
        end else if (ctrl.zlo_out) begin
            bus = z;
        end else if (ctrl.r_out || ctrl.ba_out) begin
            bus = rf_rdata;
        end else if (ctrl.c_out) begin
            bus = c_ext;
        end else begin
            bus = '0;
        end
    end

    assign is_shift = ctrl.alu_op inside {alu_shr, alu_shra, alu_shl, alu_ror, alu_rol};
    assign z_d = ctrl.pc_increment ? pc + 32'd1 : (is_shift ? rot_result : alu_result);

    always_comb begin
        case (cond)
            2'b00:   cond_met = (bus == '0);
            2'b01:   cond_met = (bus != '0);
            2'b10:   cond_met = ~bus[31];    // sign bit clear
            default: cond_met = bus[31];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
            ir_q <= '0;
            con_ff <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (ctrl.pc_en) pc <= bus;
            if (ctrl.ir_en) ir_q <= bus;
            if (ctrl.con_en) con_ff <= cond_met;
            out_valid <= ctrl.outport_en;  // single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.y_clr) begin
            y <= '0;
        end else if (ctrl.y_en) begin
            y <= bus;
        end
        if (ctrl.z_en) z <= z_d;
        if (ctrl.mar_en) mar <= bus;
        if (ctrl.mdr_en) mdr <= ctrl.read ? mem_rdata : bus;
        if (ctrl.outport_en) out_data <= bus;
    end

    assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.pc_out, ctrl.mdr_out, ctrl.zlo_out, ctrl.r_out, ctrl.ba_out, ctrl.c_out}));

endmodule

//--- src/control_unit.sv
`timescale 1ns/1ps

module control_unit import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] ir,
    input  logic        con_ff,
    output ctrl_t       ctrl,
    output logic        halted
);

    state_t state, next;
    alu_op_t op_q, dec_op;
    logic [opcode_w-1:0] opcode;

    assign opcode = ir[data_w-1 -: opcode_w];
    assign halted = (state == halted_state);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= reset_state;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            reset_state: next = fetch0;
            fetch0:      next = fetch1;
            fetch1:      next = fetch2;
            fetch2: begin
                case (opcode)
                    op_ld:   next = ld3;
                    op_ldi:  next = ldi3;
                    op_st:   next = st3;
                    op_add, op_sub, op_and, op_or,
                    op_shr, op_shra, op_shl, op_ror, op_rol: next = reg3;
                    op_addi, op_andi, op_ori: next = imm3;
                    op_neg, op_not: next = un3;
                    op_branch: next = br3;
                    op_out:  next = out3;
                    op_halt: next = halted_state;
                    default: next = nop3;   // unknown opcodes too
                endcase
            end
            ld3:  next = ld4;
            ld4:  next = ld5;
            ld5:  next = ld6;
            ld6:  next = ld7;
            ldi3: next = ldi4;
            ldi4: next = ldi5;
            st3:  next = st4;
            st4:  next = st5;
            st5:  next = st6;
            st6:  next = st7;
            reg3: next = reg4;
            reg4: next = reg5;
            imm3: next = imm4;
            imm4: next = imm5;
            un3:  next = un4;
            br3:  next = br4;
            br4:  next = br5;
            br5:  next = con_ff ? br6 : br6_nt;  // con_ff set back in br3
            halted_state: next = halted_state;
            default: next = fetch0;             // last state of every class
        endcase
    end

    // alu operation latched once per instruction
    always_comb begin
        case (opcode)
            op_sub:          dec_op = alu_sub;
            op_and, op_andi: dec_op = alu_and;
            op_or, op_ori:   dec_op = alu_or;
            op_neg:          dec_op = alu_neg;
            op_not:          dec_op = alu_not;
            op_shr:          dec_op = alu_shr;
            op_shra:         dec_op = alu_shra;
            op_shl:          dec_op = alu_shl;
            op_ror:          dec_op = alu_ror;
            op_rol:          dec_op = alu_rol;
            default:         dec_op = alu_add;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_q <= alu_add;
        end else if (state == fetch2) begin
            op_q <= dec_op;
        end
    end

    always_comb begin
        ctrl = '0;
        case (state)
            fetch0: begin
                ctrl.pc_out = 1'b1;
                ctrl.mar_en = 1'b1;
                ctrl.pc_increment = 1'b1;  // z <= pc + 1
                ctrl.z_en = 1'b1;
                ctrl.y_clr = 1'b1;
            end
            fetch1: begin
                ctrl.read = 1'b1;
                ctrl.mdr_en = 1'b1;
                ctrl.zlo_out = 1'b1;
                ctrl.pc_en = 1'b1;
            end
            fetch2, ld7: begin
                ctrl.read = 1'b1;   // keeps mdr following the ram output
                ctrl.mdr_en = 1'b1;
                ctrl.mdr_out = 1'b1;
                ctrl.ir_en = (state == fetch2);
                ctrl.gra = (state == ld7);
                ctrl.r_in = (state == ld7);
            end
            ld3, ldi3, st3: begin
                ctrl.grb = 1'b1;
                ctrl.ba_out = 1'b1;    // r0 base reads as zero
                ctrl.y_en = 1'b1;
            end
            ld4, ldi4, st4, br5: begin
                ctrl.c_out = 1'b1;
                ctrl.z_en = 1'b1;
            end
            ld5, st5: begin
                ctrl.zlo_out = 1'b1;
                ctrl.mar_en = 1'b1;
            end
            ld6: begin
                ctrl.read = 1'b1;
                ctrl.mdr_en = 1'b1;
            end
            st6: begin
                ctrl.gra = 1'b1;
                ctrl.r_out = 1'b1;
                ctrl.mdr_en = 1'b1;
            end
            st7: ctrl.write = 1'b1;
            reg3, imm3: begin
                ctrl.grb = 1'b1;
                ctrl.r_out = 1'b1;
                ctrl.y_en = 1'b1;
            end
            reg4, imm4, un3: begin
                ctrl.grc = (state == reg4);
                ctrl.grb = (state == un3);   // neg/not act on rb
                ctrl.r_out = (state != imm4);
                ctrl.c_out = (state == imm4);
                ctrl.z_en = 1'b1;
                ctrl.alu_op = op_q;
            end
            ldi5, reg5, imm5, un4: begin
                ctrl.zlo_out = 1'b1;
                ctrl.gra = 1'b1;
                ctrl.r_in = 1'b1;
            end
            br3, out3: begin
                ctrl.gra = 1'b1;
                ctrl.r_out = 1'b1;
                ctrl.con_en = (state == br3);
                ctrl.outport_en = (state == out3);
            end
            br4: begin
                ctrl.pc_out = 1'b1;
                ctrl.y_en = 1'b1;
            end
            br6: begin
                ctrl.zlo_out = 1'b1;
                ctrl.pc_en = 1'b1;
            end
            default: ctrl = '0;   // reset, nop, untaken branch, halted
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) !(ctrl.read && ctrl.write));
    assert property (@(posedge clk) disable iff (reset) halted |=> halted);

endmodule

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_en,
    input  logic [mem_addr_w-1:0] load_addr,
    input  logic [31:0]           load_data,
    output logic [31:0]           out_data,
    output logic                  out_valid,
    output logic                  halted
);

    ctrl_t ctrl;
    logic [31:0] ir;
    logic con_ff;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;

    control_unit control_unit_inst (
        .clk    (clk),
        .reset  (reset),
        .ir     (ir),
        .con_ff (con_ff),
        .ctrl   (ctrl),
        .halted (halted)
    );

    datapath datapath_inst (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .ir        (ir),
        .con_ff    (con_ff),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

    memory memory_inst (
        .clk       (clk),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .read      (ctrl.read),
        .write     (ctrl.write),
        .rdata     (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

//--- tb/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    logic clk = 1'b0;
    logic reset;
    logic load_en;
    logic [mem_addr_w-1:0] load_addr;
    logic [31:0] load_data;
    logic [31:0] out_data;
    logic out_valid;
    logic halted;

    // reference model state
    logic [31:0] rm [16];
    logic [31:0] mm [mem_words];
    logic [mem_addr_w-1:0] addr_q [$];
    logic [31:0] data_q [$];
    logic [4:0] ops [$];
    int pc;
    int t;                          // cycle at which the next instruction enters fetch0

    // expected outport values and the cycle each pulse is due
    logic [31:0] exp_val [64];
    int exp_cyc [64];
    int exp_cnt;
    int out_idx;
    int run_cyc;
    logic [31:0] exp_now;
    int exp_at;

    integer seed;
    int errors = 0;
    int tests = 0;
    int failed = 0;
    int cycles = 0;
    int cycle_limit = 50;

    cpu_top cpu_top_inst (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted)
    );

    always #2 clk = ~clk;

    assign exp_now = exp_val[out_idx[5:0]];
    assign exp_at = exp_cyc[out_idx[5:0]];

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            run_cyc <= 0;
            out_idx <= 0;
        end else begin
            run_cyc <= run_cyc + 1;
            if (out_valid) out_idx <= out_idx + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    assert property (@(posedge clk) $fell(reset) |-> !out_valid && !halted)
        else begin
            errors++;
            $display("out_valid or halted high right after reset");
        end

    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_idx < exp_cnt)
        else begin
            errors++;
            $display("out_valid pulsed with no output expected");
        end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_idx < exp_cnt |-> out_data == exp_now)
        else begin
            errors++;
            $display("Error out_data = 0x%h, expected 0x%h",
                     $sampled(out_data), $sampled(exp_now));
        end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_idx < exp_cnt |-> run_cyc == exp_at)
        else begin
            errors++;
            $display("out_valid pulse came at cycle %0d instead of cycle %0d",
                     $sampled(run_cyc), $sampled(exp_at));
        end

    function automatic logic [18:0] rnd19();
        logic [31:0] r;
        r = $random(seed);
        return r[18:0];
    endfunction

    function automatic logic [3:0] rnd_reg();
        int r;
        r = 1 + rnd19() % 12;       // r13..r15 reserved for branch tests
        return r[3:0];
    endfunction

    function automatic logic [31:0] sext(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [4:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        int n;
        n = b[4:0];
        case (op)
            op_add, op_addi: return a + b;
            op_sub:          return a - b;
            op_and, op_andi: return a & b;
            op_or, op_ori:   return a | b;
            op_neg:          return 32'd0 - b;
            op_not:          return ~b;
            op_shr:          return a >> n;
            op_shra:         return $signed(a) >>> n;
            op_shl:          return a << n;
            op_ror:          return (a >> n) | (a << (32 - n));
            default:         return (a << n) | (a >> (32 - n));
        endcase
    endfunction

    task automatic new_program();
        addr_q.delete();
        data_q.delete();
        pc = 0;
        t = 1;
        exp_cnt = 0;
        for (int r = 0; r < 16; r++) rm[r] = '0;
    endtask

    task automatic put_word(input logic [31:0] w);
        addr_q.push_back(pc[mem_addr_w-1:0]);
        data_q.push_back(w);
        mm[pc] = w;
        pc++;
    endtask

    task automatic poke_word(input int a, input logic [31:0] w);
        addr_q.push_back(a[mem_addr_w-1:0]);
        data_q.push_back(w);
        mm[a] = w;
    endtask

    task automatic spend(input int exec);
        t += 3 + exec;      // fetch plus execute states
    endtask

    task automatic alu_instr(input logic [4:0] op, input logic [3:0] ra, input logic [3:0] rb,
                             input logic [18:0] x);
        logic [31:0] b;
        int n;
        if (op == op_addi || op == op_andi || op == op_ori) begin
            b = sext(x);
            n = 3;
        end else if (op == op_neg || op == op_not) begin
            b = rm[rb];
            n = 2;
        end else begin
            b = rm[x[18:15]];   // rc field
            n = 3;
        end
        put_word({op, ra, rb, x});
        spend(n);
        rm[ra] = alu_ref(op, rm[rb], b);
    endtask

    task automatic mem_instr(input logic [4:0] op, input logic [3:0] ra, input logic [3:0] rb,
                             input logic [18:0] c);
        logic [31:0] ea;
        ea = ((rb == 0) ? 32'd0 : rm[rb]) + sext(c);
        put_word({op, ra, rb, c});
        if (op == op_ldi) begin
            spend(3);
            rm[ra] = ea;
        end else if (op == op_ld) begin
            spend(5);
            rm[ra] = mm[ea[mem_addr_w-1:0]];
        end else begin
            spend(5);
            mm[ea[mem_addr_w-1:0]] = rm[ra];
        end
    endtask

    task automatic out_instr(input logic [3:0] ra);
        exp_val[exp_cnt] = rm[ra];
        exp_cyc[exp_cnt] = t + 4;
        exp_cnt++;
        put_word({op_out, ra, 23'd0});
        spend(1);
    endtask

    task automatic halt_instr();
        put_word({op_halt, 27'd0});
        spend(0);
    endtask

    // taken path outputs r13 and fall-through outputs r14
    task automatic branch_pair(input logic [3:0] ra, input logic [1:0] cond);
        logic taken;
        case (cond)
            2'd0:    taken = (rm[ra] == 0);
            2'd1:    taken = (rm[ra] != 0);
            2'd2:    taken = ($signed(rm[ra]) > 0);
            default: taken = rm[ra][31];
        endcase
        put_word({op_branch, ra, 2'b00, cond, 19'd2});
        spend(4);
        if (taken) begin
            put_word({op_out, 4'd14, 23'd0});
            put_word({op_branch, 4'd15, 4'd0, 19'd1});
            out_instr(4'd13);
        end else begin
            out_instr(4'd14);
            put_word({op_branch, 4'd15, 4'd0, 19'd1});   // r15 is never written
            spend(4);
            put_word({op_out, 4'd13, 23'd0});
        end
    endtask

    task automatic run_program(input string name);
        int err0;
        int hold;
        int i;
        int n;
        err0 = errors;
        hold = (addr_q.size() > 8) ? addr_q.size() : 8;
        cycle_limit += hold + t + 40;
        @(negedge clk);
        reset = 1'b1;
        for (i = 0; i < hold; i++) begin
            load_en = (i < addr_q.size());
            if (i < addr_q.size()) begin
                load_addr = addr_q[i];
                load_data = data_q[i];
            end
            @(negedge clk);
        end
        load_en = 1'b0;
        reset = 1'b0;
        n = 0;
        while (!halted && n < t + 20) begin
            @(negedge clk);
            n++;
        end
        assert (halted)
            else begin
                errors++;
                $display("halted did not rise within %0d cycles", t + 20);
            end
        assert (out_idx == exp_cnt)
            else begin
                errors++;
                $display("saw %0d of %0d outputs", out_idx, exp_cnt);
            end
        tests++;
        if (errors != err0) failed++;
        $display("test %s %s", name, (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        logic [3:0] a;
        logic [3:0] b;
        logic [3:0] d;
        logic [18:0] c;
        int i;
        int base;
        int abs_addr;
        seed = 32'h1f29;
        reset = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;

        new_program();
        halt_instr();
        run_program("halt_only");

        new_program();
        ops = '{op_add, op_sub, op_and, op_or};
        for (i = 0; i < ops.size(); i++) begin
            a = rnd_reg();
            b = rnd_reg();
            d = rnd_reg();
            mem_instr(op_ldi, a, 4'd0, rnd19());
            mem_instr(op_ldi, b, 4'd0, rnd19());
            alu_instr(ops[i], d, a, {b, 15'd0});
            out_instr(d);
        end
        halt_instr();
        run_program("reg_alu");

        new_program();
        ops = '{op_addi, op_andi, op_ori, op_neg, op_not};
        for (i = 0; i < ops.size(); i++) begin
            a = rnd_reg();
            d = rnd_reg();
            c = (ops[i] == op_neg || ops[i] == op_not) ? 19'd0 : rnd19();
            mem_instr(op_ldi, a, 4'd0, rnd19());
            alu_instr(ops[i], d, a, c);
            out_instr(d);
        end
        halt_instr();
        run_program("imm_unary");

        new_program();
        ops = '{op_shr, op_shra, op_shl, op_ror, op_rol};
        for (i = 0; i < ops.size(); i++) begin
            mem_instr(op_ldi, 4'd1, 4'd0, rnd19());
            mem_instr(op_ldi, 4'd2, 4'd0, rnd19());   // amount in the low 5 bits
            alu_instr(ops[i], 4'd3, 4'd1, {4'd2, 15'd0});
            out_instr(4'd3);
        end
        halt_instr();
        run_program("shifts");

        new_program();
        base = 256 + rnd19() % 128;     // clear of the program words
        c = rnd19() % 64;
        mem_instr(op_ldi, 4'd1, 4'd0, base[18:0]);
        mem_instr(op_ldi, 4'd2, 4'd0, rnd19());
        mem_instr(op_st, 4'd2, 4'd1, c);
        mem_instr(op_ld, 4'd3, 4'd1, c);
        out_instr(4'd3);
        abs_addr = 480 + rnd19() % 32;
        poke_word(abs_addr, $random(seed));
        mem_instr(op_ld, 4'd4, 4'd0, abs_addr[18:0]);
        out_instr(4'd4);
        halt_instr();
        run_program("load_store");

        new_program();
        mem_instr(op_ldi, 4'd13, 4'd0, 19'h1aced);
        mem_instr(op_ldi, 4'd14, 4'd0, 19'h0f00d);
        for (i = 0; i < 8; i++) begin
            c = rnd19() | 19'd1;
            if (i < 4) begin
                c = i[0] ? c : 19'd0;     // zero and nonzero operands
            end else begin
                c[18] = i[0];             // positive and negative operands
            end
            mem_instr(op_ldi, 4'd5, 4'd0, c);
            branch_pair(4'd5, i[2:1]);
        end
        halt_instr();
        run_program("branches");

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/cpu_pkg.sv
src/alu.sv
src/rotator.sv
src/reg_file.sv
src/memory.sv
src/datapath.sv
src/control_unit.sv
src/cpu_top.sv
tb/cpu_tb.sv

//--- Bender.yml
package:
  name: src_cpu

sources:
  - src/cpu_pkg.sv
  - src/alu.sv
  - src/rotator.sv
  - src/reg_file.sv
  - src/memory.sv
  - src/datapath.sv
  - src/control_unit.sv
  - src/cpu_top.sv
  - target: test
    files:
      - tb/cpu_tb.sv
